/* hw/timer_defines.svh */
// --------------------------------------
// Timer build constants
// Bus widths, divider width, register
// offsets and control bit positions
// --------------------------------------

`ifndef TIMER_DEFINES_SVH
`define TIMER_DEFINES_SVH

// Bus widths
`define TIMER_ADDR_W            5
`define TIMER_DATA_W            32

// Clock divider width
`define TIMER_DIV_W             10

// Register offsets, byte addressed
`define TIMER_OFS_CONTROL       5'h00
`define TIMER_OFS_DIVIDER       5'h04
`define TIMER_OFS_MTIMELO       5'h08
`define TIMER_OFS_MTIMEHI       5'h0C
`define TIMER_OFS_MTIMECMPLO    5'h10
`define TIMER_OFS_MTIMECMPHI    5'h14

// CONTROL layout
`define TIMER_CTRL_EN_BIT       0
// Counting runs straight out of reset
`define TIMER_EN_RESET          1'b1

`endif

/* hw/timer_pkg.sv */
// --------------------------------------
// Timer types
// Bus command and response encodings,
// register select and write-data views
// --------------------------------------

`default_nettype none

`include "timer_defines.svh"

package timer_pkg;

    // Data memory bus encodings
    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'b00,
        MEM_WIDTH_HWORD = 2'b01,
        MEM_WIDTH_WORD  = 2'b10
    } mem_width_e;

    // RDY_ER exists on the bus, never sent by the timer
    typedef enum logic [1:0] {
        MEM_RESP_NOTRDY = 2'b00,
        MEM_RESP_RDY_OK = 2'b01,
        MEM_RESP_RDY_ER = 2'b10
    } mem_resp_e;

    // Select equals the word index of the register
    typedef enum logic [2:0] {
        SEL_CONTROL    = 3'(`TIMER_OFS_CONTROL >> 2),
        SEL_DIVIDER    = 3'(`TIMER_OFS_DIVIDER >> 2),
        SEL_MTIMELO    = 3'(`TIMER_OFS_MTIMELO >> 2),
        SEL_MTIMEHI    = 3'(`TIMER_OFS_MTIMEHI >> 2),
        SEL_MTIMECMPLO = 3'(`TIMER_OFS_MTIMECMPLO >> 2),
        SEL_MTIMECMPHI = 3'(`TIMER_OFS_MTIMECMPHI >> 2)
    } timer_sel_e;

    // Same write word, seen as CONTROL or as DIVIDER
    typedef union packed {
        struct packed {
            logic [`TIMER_DATA_W-1:1]            rsvd;
            logic                                en;
        } ctrl;
        struct packed {
            logic [`TIMER_DATA_W-`TIMER_DIV_W-1:0] rsvd;
            logic [`TIMER_DIV_W-1:0]               div;
        } divr;
    } timer_wdata_u;

endpackage

`default_nettype wire

/* hw/timer_reg_if.sv */
// --------------------------------------
// Decoded register access and timer
// state shared by decode, execute and
// result stages
// --------------------------------------

`default_nettype none

`include "timer_defines.svh"

interface timer_reg_if import timer_pkg::*; ();

    // Access strobes, one cycle each
    logic                    acc_wr;
    logic                    acc_rd;
    // Access payload
    timer_sel_e              acc_sel;
    timer_wdata_u            acc_wdata;

    // Register state
    logic                    timer_en;
    logic [`TIMER_DIV_W-1:0] timer_div;
    logic [63:0]             mtime;
    logic [63:0]             mtimecmp;

    // Bus side, produces the access
    modport decode (
        output acc_wr, acc_rd, acc_sel, acc_wdata
    );

    // Owns every register
    modport execute (
        input  acc_wr, acc_sel, acc_wdata,
        output timer_en, timer_div, mtime, mtimecmp
    );

    // Response path, write strobe needed for write acks on the bus
    modport result (
        input  acc_wr, acc_rd, acc_sel,
        input  timer_en, timer_div, mtime, mtimecmp
    );

endinterface

`default_nettype wire

/* hw/timer_decode.sv */
// --------------------------------------
// Bus request front end
// Ack generation, request filtering and
// registered access strobes
// --------------------------------------

`default_nettype none

`include "timer_defines.svh"

module timer_decode import timer_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,

    // Data memory request side
    input  logic                     dmem_req,
    input  mem_cmd_e                 dmem_cmd,
    input  mem_width_e               dmem_width,
    input  logic [`TIMER_ADDR_W-1:0] dmem_addr,
    input  logic [`TIMER_DATA_W-1:0] dmem_wdata,
    output logic                     dmem_req_ack,

    // Decoded access toward execute and result
    timer_reg_if.decode              regs
);

    // Last implemented register bounds the address map
    localparam logic [`TIMER_ADDR_W-1:0] LAST_OFS = `TIMER_OFS_MTIMECMPHI;

    logic req_new;
    logic width_ok;
    logic align_ok;
    logic range_ok;
    logic req_ok;

    // --------------------------------------
    // Request filter
    // --------------------------------------

    // Fresh request only, ack cycle is ignored
    assign req_new  = dmem_req & ~dmem_req_ack;

    // Word accesses only
    assign width_ok = (dmem_width == MEM_WIDTH_WORD);
    // Two low address bits must be clear
    assign align_ok = (dmem_addr[1:0] == 2'b00);
    // Word index up to MTIMECMPHI
    assign range_ok = (dmem_addr[`TIMER_ADDR_W-1:2] <= LAST_OFS[`TIMER_ADDR_W-1:2]);

    assign req_ok   = req_new & width_ok & align_ok & range_ok;

    // --------------------------------------
    // Ack and strobes
    // --------------------------------------

    // Ack every fresh request, filtered or not
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dmem_req_ack <= 1'b0;
        end else begin
            dmem_req_ack <= req_new;
        end
    end

    // Command split into write and read strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs.acc_wr <= 1'b0;
            regs.acc_rd <= 1'b0;
        end else begin
            regs.acc_wr <= req_ok & (dmem_cmd == MEM_CMD_WR);
            regs.acc_rd <= req_ok & (dmem_cmd == MEM_CMD_RD);
        end
    end

    // --------------------------------------
    // Access payload
    // --------------------------------------

    // Captured on any fresh request
    // Only looked at while a strobe is high
    always_ff @(posedge clk) begin
        if (req_new) begin
            regs.acc_sel   <= timer_sel_e'(dmem_addr[`TIMER_ADDR_W-1:2]);
            regs.acc_wdata <= dmem_wdata;
        end
    end

endmodule

`default_nettype wire

/* hw/timer_execute.sv */
// --------------------------------------
// Timer register file
// CONTROL, DIVIDER, mtime, mtimecmp and
// the timer interrupt
// --------------------------------------

`default_nettype none

`include "timer_defines.svh"

module timer_execute import timer_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,

    // Access in, register state out
    timer_reg_if.execute  regs,

    output logic          timer_irq
);

    // Per-register write enables
    logic                    ctrl_wr;
    logic                    div_wr;
    logic                    lo_wr;
    logic                    hi_wr;
    logic                    cmplo_wr;
    logic                    cmphi_wr;
    logic                    cmp_wr;
    logic [31:0]             wword;

    logic                    timer_en;
    logic [`TIMER_DIV_W-1:0] timer_div;
    logic [`TIMER_DIV_W-1:0] div_cnt;
    logic                    tick;

    logic [31:0]             mtime_lo;
    logic [31:0]             mtime_hi;
    logic [31:0]             lo_inc;
    logic                    lo_carry;

    logic [63:0]             mtimecmp;
    logic [63:0]             cmp_new;
    logic                    cmp_hit;

    // --------------------------------------
    // Write decode
    // --------------------------------------
    assign ctrl_wr  = regs.acc_wr & (regs.acc_sel == SEL_CONTROL);
    assign div_wr   = regs.acc_wr & (regs.acc_sel == SEL_DIVIDER);
    assign lo_wr    = regs.acc_wr & (regs.acc_sel == SEL_MTIMELO);
    assign hi_wr    = regs.acc_wr & (regs.acc_sel == SEL_MTIMEHI);
    assign cmplo_wr = regs.acc_wr & (regs.acc_sel == SEL_MTIMECMPLO);
    assign cmphi_wr = regs.acc_wr & (regs.acc_sel == SEL_MTIMECMPHI);
    assign cmp_wr   = cmplo_wr | cmphi_wr;

    // Flat view for the time registers
    assign wword    = regs.acc_wdata;

    // CONTROL and DIVIDER, each through its own view
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer_en  <= `TIMER_EN_RESET;
            timer_div <= '0;
        end else begin
            if (ctrl_wr) begin
                timer_en <= regs.acc_wdata.ctrl.en;
            end
            if (div_wr) begin
                timer_div <= regs.acc_wdata.divr.div;
            end
        end
    end

    // --------------------------------------
    // Divider down-counter
    // --------------------------------------

    // One tick every timer_div+1 enabled cycles
    assign tick = timer_en & (div_cnt == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (div_wr) begin
            // Restart the period from the new value
            div_cnt <= regs.acc_wdata.divr.div;
        end else if (tick) begin
            div_cnt <= timer_div;
        end else if (timer_en) begin
            div_cnt <= div_cnt - 1'b1;
        end
    end

    // --------------------------------------
    // mtime, split 32-bit increment
    // --------------------------------------
    assign lo_inc = mtime_lo + 32'd1;

    // lo_carry marks a low word of all ones, so the high adder
    // never waits on the low carry chain
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime_lo <= '0;
            mtime_hi <= '0;
            lo_carry <= 1'b0;
        end else if (tick) begin
            // Tick wins over a same-cycle write
            mtime_lo <= lo_inc;
            mtime_hi <= mtime_hi + 32'(lo_carry);
            lo_carry <= &lo_inc;
        end else begin
            if (lo_wr) begin
                mtime_lo <= wword;
                lo_carry <= &wword;
            end
            if (hi_wr) begin
                mtime_hi <= wword;
            end
        end
    end

    // --------------------------------------
    // mtimecmp and interrupt
    // --------------------------------------
    always_comb begin
        cmp_new = mtimecmp;
        if (cmplo_wr) begin
            cmp_new[31:0] = wword;
        end
        if (cmphi_wr) begin
            cmp_new[63:32] = wword;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp <= '0;
        end else if (cmp_wr) begin
            mtimecmp <= cmp_new;
        end
    end

    // Compare against the incoming value during a compare write
    assign cmp_hit = ({mtime_hi, mtime_lo} >= (cmp_wr ? cmp_new : mtimecmp));

    // Sticky once set, cleared only by a compare write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer_irq <= 1'b0;
        end else if (!timer_irq || cmp_wr) begin
            timer_irq <= cmp_hit;
        end
    end

    // State toward the response path and the top level
    assign regs.timer_en  = timer_en;
    assign regs.timer_div = timer_div;
    assign regs.mtime     = {mtime_hi, mtime_lo};
    assign regs.mtimecmp  = mtimecmp;

endmodule

`default_nettype wire

/* hw/timer_result.sv */
// --------------------------------------
// Read-data mux and registered bus
// response
// --------------------------------------

`default_nettype none

`include "timer_defines.svh"

module timer_result import timer_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,

    // Access strobes and register state
    timer_reg_if.result              regs,

    // Data memory response side
    output logic [`TIMER_DATA_W-1:0] dmem_rdata,
    output mem_resp_e                dmem_resp
);

    logic [`TIMER_DATA_W-1:0] rd_word;
    logic                     acc_any;

    // Either strobe earns a response
    assign acc_any = regs.acc_wr | regs.acc_rd;

    // --------------------------------------
    // Read mux
    // --------------------------------------
    always_comb begin
        rd_word = '0;
        case (regs.acc_sel)
            SEL_CONTROL: begin
                rd_word[`TIMER_CTRL_EN_BIT] = regs.timer_en;
            end
            SEL_DIVIDER: begin
                // Zero-extended
                rd_word = `TIMER_DATA_W'(regs.timer_div);
            end
            SEL_MTIMELO: begin
                rd_word = regs.mtime[31:0];
            end
            SEL_MTIMEHI: begin
                rd_word = regs.mtime[63:32];
            end
            SEL_MTIMECMPLO: begin
                rd_word = regs.mtimecmp[31:0];
            end
            SEL_MTIMECMPHI: begin
                rd_word = regs.mtimecmp[63:32];
            end
            default: begin
                rd_word = '0;
            end
        endcase
    end

    // --------------------------------------
    // Response register
    // --------------------------------------

    // One RDY_OK cycle per strobe, data only for reads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dmem_resp  <= MEM_RESP_NOTRDY;
            dmem_rdata <= '0;
        end else if (acc_any) begin
            dmem_resp  <= MEM_RESP_RDY_OK;
            dmem_rdata <= regs.acc_rd ? rd_word : '0;
        end else begin
            dmem_resp  <= MEM_RESP_NOTRDY;
            dmem_rdata <= '0;
        end
    end

endmodule

`default_nettype wire

/* hw/mmio_timer.sv */
// --------------------------------------
// Memory-mapped machine timer, top level
// Decode, execute and result stages
// joined by one register interface
// --------------------------------------

`default_nettype none

`include "timer_defines.svh"

module mmio_timer import timer_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,

    // Data memory port
    input  logic                     dmem_req,
    input  mem_cmd_e                 dmem_cmd,
    input  mem_width_e               dmem_width,
    input  logic [`TIMER_ADDR_W-1:0] dmem_addr,
    input  logic [`TIMER_DATA_W-1:0] dmem_wdata,
    output logic                     dmem_req_ack,
    output logic [`TIMER_DATA_W-1:0] dmem_rdata,
    output mem_resp_e                dmem_resp,

    // Timer outputs
    output logic [63:0]              timer_val,
    output logic                     timer_irq
);

    // Access and state between the stages
    timer_reg_if regs_if ();

    // Request side
    timer_decode timer_decode_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .dmem_req     (dmem_req),
        .dmem_cmd     (dmem_cmd),
        .dmem_width   (dmem_width),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_req_ack (dmem_req_ack),
        .regs         (regs_if.decode)
    );

    // Registers, counter and interrupt
    timer_execute timer_execute_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .regs      (regs_if.execute),
        .timer_irq (timer_irq)
    );

    // Response side
    timer_result timer_result_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .regs       (regs_if.result),
        .dmem_rdata (dmem_rdata),
        .dmem_resp  (dmem_resp)
    );

    // Live counter value, no extra stage
    assign timer_val = regs_if.mtime;

endmodule

`default_nettype wire

/* tests/mmio_timer_props.sv */
// --------------------------------------
// Bus protocol and interrupt assertions
// for the MMIO timer, bound to its top
// --------------------------------------

`default_nettype none

`include "timer_defines.svh"

module mmio_timer_props import timer_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     dmem_req,
    input  mem_cmd_e                 dmem_cmd,
    input  mem_width_e               dmem_width,
    input  logic [`TIMER_ADDR_W-1:0] dmem_addr,
    input  logic                     dmem_req_ack,
    input  mem_resp_e                dmem_resp,
    input  logic                     timer_irq
);

    logic req_new;
    logic req_valid;
    logic cmp_wr_req;
    logic cmp_wr_d1;
    logic cmp_wr_d2;

    // Request sampled by the DUT on this edge
    assign req_new    = dmem_req & ~dmem_req_ack;
    assign req_valid  = req_new & (dmem_width == MEM_WIDTH_WORD) & (dmem_addr[1:0] == 2'b00)
                        & (dmem_addr[`TIMER_ADDR_W-1:2] <= 3'(`TIMER_OFS_MTIMECMPHI >> 2));
    // Valid write into either compare half
    assign cmp_wr_req = req_valid & (dmem_cmd == MEM_CMD_WR)
                        & ((dmem_addr == `TIMER_OFS_MTIMECMPLO)
                        | (dmem_addr == `TIMER_OFS_MTIMECMPHI));

    // Compare write lands two edges after sampling
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmp_wr_d1 <= 1'b0;
            cmp_wr_d2 <= 1'b0;
        end else begin
            cmp_wr_d1 <= cmp_wr_req;
            cmp_wr_d2 <= cmp_wr_d1;
        end
    end

    // --------------------------------------
    // Bus protocol
    // --------------------------------------
    ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        req_new |=> dmem_req_ack)
        else $error("ack missing after a sampled request");

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req_ack |=> !dmem_req_ack)
        else $error("ack high for more than one cycle");

    resp_latency: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> ##2 (dmem_resp == MEM_RESP_RDY_OK))
        else $error("no RDY_OK two cycles after a valid request");

    resp_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        (dmem_resp == MEM_RESP_RDY_OK) |=> (dmem_resp == MEM_RESP_NOTRDY))
        else $error("response strobe longer than one cycle");

    // --------------------------------------
    // Interrupt
    // --------------------------------------
    irq_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(timer_irq) |-> cmp_wr_d2)
        else $error("timer_irq fell without a compare write");

endmodule

bind mmio_timer mmio_timer_props mmio_timer_props_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .dmem_req     (dmem_req),
    .dmem_cmd     (dmem_cmd),
    .dmem_width   (dmem_width),
    .dmem_addr    (dmem_addr),
    .dmem_req_ack (dmem_req_ack),
    .dmem_resp    (dmem_resp),
    .timer_irq    (timer_irq)
);

`default_nettype wire

/* tests/tb_mmio_timer.sv */
// --------------------------------------
// Testbench for the MMIO machine timer
// Bus driver, reference model, response
// checker and watchdog
// --------------------------------------

`default_nettype none

`include "timer_defines.svh"

module tb_mmio_timer import timer_pkg::*; ();

    localparam int CLK_PERIOD  = 8;
    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 1500;
    localparam int MARGIN      = 500;

    logic                     clk;
    logic                     rst_n;
    logic                     dmem_req;
    mem_cmd_e                 dmem_cmd;
    mem_width_e               dmem_width;
    logic [`TIMER_ADDR_W-1:0] dmem_addr;
    logic [`TIMER_DATA_W-1:0] dmem_wdata;
    logic                     dmem_req_ack;
    logic [`TIMER_DATA_W-1:0] dmem_rdata;
    mem_resp_e                dmem_resp;
    logic [63:0]              timer_val;
    logic                     timer_irq;

    // Shadow registers for the reference model
    logic                     sh_en;
    logic [`TIMER_DIV_W-1:0]  sh_div;
    logic [63:0]              sh_mtime;
    logic [63:0]              sh_cmp;

    // Pending valid accesses, oldest first
    bit                       exp_rd_q[$];
    logic [31:0]              exp_data_q[$];

    logic [31:0]              lfsr;
    int                       checks     = 0;
    int                       value_errs = 0;
    int                       other_errs = 0;

    mmio_timer mmio_timer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .dmem_req     (dmem_req),
        .dmem_cmd     (dmem_cmd),
        .dmem_width   (dmem_width),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_req_ack (dmem_req_ack),
        .dmem_rdata   (dmem_rdata),
        .dmem_resp    (dmem_resp),
        .timer_val    (timer_val),
        .timer_irq    (timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------------------------
    // Random data and reference model
    // --------------------------------------

    // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // Word a read should return, from the shadow state
    function automatic logic [31:0] expected_read(input logic [`TIMER_ADDR_W-1:0] addr);
        case (addr)
            `TIMER_OFS_CONTROL:    return 32'(sh_en);
            `TIMER_OFS_DIVIDER:    return 32'(sh_div);
            `TIMER_OFS_MTIMELO:    return sh_mtime[31:0];
            `TIMER_OFS_MTIMEHI:    return sh_mtime[63:32];
            `TIMER_OFS_MTIMECMPLO: return sh_cmp[31:0];
            `TIMER_OFS_MTIMECMPHI: return sh_cmp[63:32];
            default:               return 32'd0;
        endcase
    endfunction

    // Divider keeps only its low bits, control only the enable
    task automatic shadow_write(input logic [`TIMER_ADDR_W-1:0] addr, input logic [31:0] data);
        case (addr)
            `TIMER_OFS_CONTROL:    sh_en = data[`TIMER_CTRL_EN_BIT];
            `TIMER_OFS_DIVIDER:    sh_div = data[`TIMER_DIV_W-1:0];
            `TIMER_OFS_MTIMELO:    sh_mtime[31:0] = data;
            `TIMER_OFS_MTIMEHI:    sh_mtime[63:32] = data;
            `TIMER_OFS_MTIMECMPLO: sh_cmp[31:0] = data;
            `TIMER_OFS_MTIMECMPHI: sh_cmp[63:32] = data;
            default:               sh_en = sh_en;
        endcase
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            value_errs++;
            $display("Error: time %0t, %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic report_failure(input string msg);
        other_errs++;
        $display("Failure at time %0t: %s", $time, msg);
    endtask

    // --------------------------------------
    // Bus driver
    // --------------------------------------
    task automatic bus_access(input mem_cmd_e cmd, input mem_width_e width,
                              input logic [`TIMER_ADDR_W-1:0] addr, input logic [31:0] wdata,
                              input bit valid, input logic [31:0] exp);
        int waited;
        waited = 0;
        @(posedge clk);
        dmem_req   <= 1'b1;
        dmem_cmd   <= cmd;
        dmem_width <= width;
        dmem_addr  <= addr;
        dmem_wdata <= wdata;
        if (valid) begin
            exp_rd_q.push_back(cmd == MEM_CMD_RD);
            exp_data_q.push_back(exp);
        end
        // Hold the request until ack shows up
        do begin
            @(negedge clk);
            waited++;
        end while (!dmem_req_ack && waited < 16);
        if (!dmem_req_ack) begin
            report_failure($sformatf("no ack for the request to address %h", addr));
        end
        @(posedge clk);
        dmem_req <= 1'b0;
        @(negedge clk);
        if (valid) begin
            check_value("dmem_resp", 64'(dmem_resp), 64'(MEM_RESP_RDY_OK));
        end else begin
            // Filtered request never gets a response
            repeat (4) begin
                check_value("dmem_resp", 64'(dmem_resp), 64'(MEM_RESP_NOTRDY));
                @(negedge clk);
            end
        end
    endtask

    task automatic bus_write(input logic [`TIMER_ADDR_W-1:0] addr, input logic [31:0] data);
        bus_access(MEM_CMD_WR, MEM_WIDTH_WORD, addr, data, 1'b1, 32'd0);
        shadow_write(addr, data);
    endtask

    task automatic bus_read(input logic [`TIMER_ADDR_W-1:0] addr);
        bus_access(MEM_CMD_RD, MEM_WIDTH_WORD, addr, 32'd0, 1'b1, expected_read(addr));
    endtask

    // Every RDY_OK is matched against the oldest pending access
    initial begin
        bit          is_rd;
        logic [31:0] exp;
        forever begin
            @(negedge clk);
            if (rst_n && dmem_resp == MEM_RESP_RDY_OK) begin
                if (exp_rd_q.size() == 0) begin
                    report_failure("bus response without a matching valid request");
                end else begin
                    is_rd = exp_rd_q.pop_front();
                    exp   = exp_data_q.pop_front();
                    if (is_rd) begin
                        check_value("dmem_rdata", 64'(dmem_rdata), 64'(exp));
                    end
                end
            end
        end
    end

    // --------------------------------------
    // Tests
    // --------------------------------------
    task automatic test_reset();
        bus_read(`TIMER_OFS_CONTROL);
        bus_read(`TIMER_OFS_DIVIDER);
        bus_read(`TIMER_OFS_MTIMEHI);
        bus_read(`TIMER_OFS_MTIMECMPLO);
        bus_read(`TIMER_OFS_MTIMECMPHI);
    endtask

    task automatic test_readback();
        logic [31:0] w;
        bus_write(`TIMER_OFS_CONTROL, 32'd0);
        for (int a = 1; a < 6; a++) begin
            rand_bits(32, w);
            bus_write(`TIMER_ADDR_W'(a * 4), w);
        end
        for (int a = 0; a < 6; a++) begin
            bus_read(`TIMER_ADDR_W'(a * 4));
        end
    endtask

    task automatic test_count();
        logic [31:0] d;
        logic [63:0] prev;
        int          cycle;
        int          last_change;
        int          changes;
        rand_bits(3, d);
        bus_write(`TIMER_OFS_DIVIDER, d);
        bus_write(`TIMER_OFS_CONTROL, 32'd1);
        prev        = timer_val;
        cycle       = 0;
        last_change = -1;
        changes     = 0;
        while (changes < 6 && cycle < 200) begin
            @(negedge clk);
            cycle++;
            if (timer_val != prev) begin
                check_value("timer_val", timer_val, prev + 64'd1);
                // First change only marks the phase
                if (last_change >= 0) begin
                    check_value("tick_interval", 64'(cycle - last_change), 64'(d) + 64'd1);
                end
                last_change = cycle;
                prev        = timer_val;
                changes++;
            end
        end
        if (changes < 6) begin
            report_failure("mtime stopped counting while enabled");
        end
    endtask

    task automatic test_carry();
        logic [31:0] hi;
        int          n;
        rand_bits(32, hi);
        bus_write(`TIMER_OFS_CONTROL, 32'd0);
        bus_write(`TIMER_OFS_DIVIDER, 32'd0);
        bus_write(`TIMER_OFS_MTIMELO, 32'hFFFF_FFFF);
        bus_write(`TIMER_OFS_MTIMEHI, hi);
        check_value("timer_val", timer_val, sh_mtime);
        bus_write(`TIMER_OFS_CONTROL, 32'd1);
        n = 0;
        while (timer_val == sh_mtime && n < 20) begin
            @(negedge clk);
            n++;
        end
        // Low word wraps, high word takes the carry
        check_value("timer_val", timer_val, {hi + 32'd1, 32'd0});
    endtask

    task automatic test_irq();
        int n;
        bus_write(`TIMER_OFS_CONTROL, 32'd0);
        bus_write(`TIMER_OFS_MTIMEHI, 32'd0);
        bus_write(`TIMER_OFS_MTIMELO, 32'h100);
        bus_write(`TIMER_OFS_MTIMECMPHI, 32'd0);
        bus_write(`TIMER_OFS_MTIMECMPLO, 32'h120);
        check_value("timer_irq", 64'(timer_irq), 64'd0);
        bus_write(`TIMER_OFS_CONTROL, 32'd1);
        n = 0;
        while (!timer_irq && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!timer_irq) begin
            report_failure("timer_irq never rose after mtime passed mtimecmp");
        end
        // Rises one edge after mtime reaches the compare value
        check_value("timer_val", timer_val, sh_cmp + 64'd1);
        repeat (8) begin
            @(negedge clk);
            check_value("timer_irq", 64'(timer_irq), 64'd1);
        end
        // mtime back below mtimecmp, no compare write
        bus_write(`TIMER_OFS_CONTROL, 32'd0);
        bus_write(`TIMER_OFS_MTIMELO, 32'h100);
        repeat (4) begin
            @(negedge clk);
            check_value("timer_irq", 64'(timer_irq), 64'd1);
        end
        bus_write(`TIMER_OFS_MTIMECMPHI, 32'd1);
        check_value("timer_irq", 64'(timer_irq), 64'd0);
        bus_write(`TIMER_OFS_CONTROL, 32'd1);
    endtask

    task automatic test_filter();
        bus_access(MEM_CMD_WR, MEM_WIDTH_BYTE, `TIMER_OFS_CONTROL, 32'd0, 1'b0, 32'd0);
        bus_access(MEM_CMD_WR, MEM_WIDTH_WORD, 5'h05, 32'h3FF, 1'b0, 32'd0);
        bus_access(MEM_CMD_RD, MEM_WIDTH_WORD, 5'h18, 32'd0, 1'b0, 32'd0);
        bus_read(`TIMER_OFS_CONTROL);
        bus_read(`TIMER_OFS_DIVIDER);
        bus_read(`TIMER_OFS_MTIMECMPLO);
        bus_read(`TIMER_OFS_MTIMECMPHI);
    endtask

    // --------------------------------------
    // Main sequence and verdict
    // --------------------------------------
    initial begin
        rst_n      = 1'b0;
        dmem_req   = 1'b0;
        dmem_cmd   = MEM_CMD_RD;
        dmem_width = MEM_WIDTH_WORD;
        dmem_addr  = '0;
        dmem_wdata = '0;
        lfsr       = 32'd79;
        sh_en      = `TIMER_EN_RESET;
        sh_div     = '0;
        sh_mtime   = '0;
        sh_cmp     = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        // Outputs while still in reset
        check_value("timer_val", timer_val, 64'd0);
        check_value("timer_irq", 64'(timer_irq), 64'd0);
        check_value("dmem_req_ack", 64'(dmem_req_ack), 64'd0);
        check_value("dmem_rdata", 64'(dmem_rdata), 64'd0);
        check_value("dmem_resp", 64'(dmem_resp), 64'(MEM_RESP_NOTRDY));
        @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_readback();
        test_count();
        test_carry();
        test_irq();
        test_filter();
        repeat (4) @(negedge clk);
        if (exp_rd_q.size() != 0) begin
            report_failure("expected bus responses never arrived");
        end
        $display("Checks run: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Bound from the test count, well above the real run length
    initial begin
        #(CLK_PERIOD * (NUM_TESTS * TEST_CYCLES + MARGIN));
        $display("Timeout: tests still running after %0d cycles",
                 NUM_TESTS * TEST_CYCLES + MARGIN);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hw
hw/timer_pkg.sv
hw/timer_reg_if.sv
hw/timer_decode.sv
hw/timer_execute.sv
hw/timer_result.sv
hw/mmio_timer.sv
tests/mmio_timer_props.sv
tests/tb_mmio_timer.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the MMIO timer testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_mmio_timer \
    --Mdir "$BUILD_DIR" \
    -f sources.f

# Keep the exit status, the log decides the verdict
status=0
"./$BUILD_DIR/Vtb_mmio_timer" > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Verification passed" "$LOG"; then
    echo "Simulation ended without a passing verdict"
    exit 1
fi
exit 0
